// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := mm_tb
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
mm_pkg.sv
tdp_ram.sv
host_sequencer.sv
mm_engine.sv
mm_system_top.sv
mm_chk.sv
mm_monitor.sv
mm_tb.sv

// File: host_sequencer.sv
module host_sequencer
  import mm_pkg::*;
(
  input  logic   arm_clk,
  input  logic   rst,
  input  logic   start,
  input  dim_t   dim_m,
  input  dim_t   dim_n,
  input  dim_t   dim_p,
  input  logic   load_valid,
  input  word_t  load_data,
  input  logic   res_credit,
  input  word_t  ctrl_rdata,
  input  word_t  out_rdata,
  output logic   done,
  output logic   load_credit,
  output logic   res_valid,
  output acc_t   res_data,
  output be_t    fm_we,
  output be_t    wm_we,
  output be_t    ctrl_we,
  output waddr_t fm_addr,
  output waddr_t wm_addr,
  output waddr_t ctrl_addr,
  output waddr_t out_addr,
  output word_t  fm_wdata,
  output word_t  wm_wdata,
  output word_t  ctrl_wdata
);

  host_state_t state;
  host_state_t state_nxt;
  dim_t        m_q;
  dim_t        n_q;
  dim_t        p_q;
  waddr_t      cnt;       // word counter of the current phase
  waddr_t      fm_total;
  waddr_t      wm_total;
  waddr_t      out_total;
  logic        fm_take;
  logic        wm_take;
  logic        rd_issue;
  logic        fm_last;
  logic        wm_last;
  logic        com_last;
  logic        rd_last;
  logic [2:0]  res_cnt;   // result credits, 0..RES_CREDITS

  assign fm_total  = waddr_t'(n_q) * waddr_t'(words_of(m_q));
  assign wm_total  = waddr_t'(n_q) * waddr_t'(words_of(p_q));
  assign out_total = waddr_t'(m_q) * waddr_t'(p_q);

  assign fm_take  = load_valid && (state == write_fm);
  assign wm_take  = load_valid && (state == write_wm);
  assign rd_issue = (state == read_out) && (res_cnt != 3'd0);

  assign fm_last  = fm_take && (cnt == fm_total - 8'd1);
  assign wm_last  = wm_take && (cnt == wm_total - 8'd1);
  assign com_last = (state == write_com) && (cnt == 8'd1);
  assign rd_last  = rd_issue && (cnt == out_total - 8'd1);

  // job dimensions, taken with the start pulse
  always_ff @(posedge arm_clk) begin
    if (state == idle && start) begin
      m_q <= dim_m;
      n_q <= dim_n;
      p_q <= dim_p;
    end
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:       if (start) state_nxt = write_fm;
      write_fm:   if (fm_last) state_nxt = write_wm;
      write_wm:   if (wm_last) state_nxt = write_com;
      write_com:  if (com_last) state_nxt = write_flag;
      write_flag: state_nxt = wait_flag;
      wait_flag:  if (ctrl_rdata == FLAG_FINISH) state_nxt = read_out;
      read_out:   if (rd_last) state_nxt = finish;
      finish:     state_nxt = idle;
      default:    state_nxt = idle;
    endcase
  end

  // every phase leaves the counter at zero
  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (fm_last || wm_last || com_last || rd_last) begin
      cnt <= '0;
    end else if (fm_take || wm_take || rd_issue || state == write_com) begin
      cnt <= cnt + 8'd1;
    end
  end

  // credit endpoints
  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      load_credit <= 1'b0;
      res_valid   <= 1'b0;
      res_cnt     <= 3'(RES_CREDITS);
    end else begin
      load_credit <= fm_take || wm_take; // one per word written
      res_valid   <= rd_issue;           // read data lands next cycle
      res_cnt     <= res_cnt - {2'b00, rd_issue} + {2'b00, res_credit};
    end
  end

  assign res_data = acc_t'(out_rdata);
  assign done     = (state == finish);

  // input words go straight to port A
  assign fm_we    = {WORD_BYTES{fm_take}};
  assign wm_we    = {WORD_BYTES{wm_take}};
  assign fm_addr  = cnt;
  assign wm_addr  = cnt;
  assign fm_wdata = load_data;
  assign wm_wdata = load_data;
  assign out_addr = cnt;

  always_comb begin
    ctrl_we    = '0;
    ctrl_addr  = CTRL_FLAG; // flag polled in wait_flag
    ctrl_wdata = '0;
    case (state)
      write_com: begin
        ctrl_we = '1;
        if (cnt == 8'd0) begin
          ctrl_addr  = CTRL_COM1;
          ctrl_wdata = {12'd0, p_q, 12'd0, m_q};
        end else begin
          ctrl_addr  = CTRL_COM2;
          ctrl_wdata = {28'd0, n_q};
        end
      end
      write_flag: begin
        ctrl_we    = '1;
        ctrl_wdata = FLAG_START;
      end
      default: ;
    endcase
  end

endmodule

// File: mm_chk.sv
module mm_chk
  import mm_pkg::*;
(
  input logic arm_clk,
  input logic rst,
  input logic load_valid,
  input logic load_credit,
  input logic res_valid,
  input logic res_credit,
  input logic done
);

  timeunit 1ns;
  timeprecision 100ps;

  int words_in;
  int load_crd;
  int res_out;       // result words out minus credits back
  int fail_cnt = 0;

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      words_in <= 0;
      load_crd <= 0;
      res_out  <= 0;
    end else begin
      words_in <= words_in + int'(load_valid);
      load_crd <= load_crd + int'(load_credit);
      res_out  <= res_out + int'(res_valid) - int'(res_credit);
    end
  end

  assert property (@(posedge arm_clk) disable iff (rst)
                   res_out + int'(res_valid) <= RES_CREDITS)
    else begin
      fail_cnt++;
      $error("result words ran ahead of the result credits");
    end

  assert property (@(posedge arm_clk) disable iff (rst)
                   load_crd + int'(load_credit) <= words_in)
    else begin
      fail_cnt++;
      $error("more input credits returned than words sent");
    end

  assert property (@(posedge arm_clk) rst |-> !done && !res_valid && !load_credit)
    else begin
      fail_cnt++;
      $error("handshake output high during reset");
    end

endmodule

bind mm_system_top mm_chk i_chk (.*);

// File: mm_engine.sv
module mm_engine
  import mm_pkg::*;
(
  input  logic   arm_clk,
  input  logic   rst,
  input  word_t  fm_rdata,
  input  word_t  wm_rdata,
  input  word_t  ctrl_rdata,
  output waddr_t fm_addr,
  output waddr_t wm_addr,
  output waddr_t ctrl_addr,
  output waddr_t out_addr,
  output be_t    ctrl_we,
  output be_t    out_we,
  output word_t  ctrl_wdata,
  output word_t  out_wdata
);

  eng_state_t         state;
  dim_t               m_q;
  dim_t               n_q;
  dim_t               p_q;
  dim_t               i_idx;
  dim_t               j_idx;
  dim_t               k_idx;
  logic [1:0]         cmd_cnt;
  logic               prod_vld;  // address pair issued last cycle
  byte_t              f_byte;
  byte_t              w_byte;
  logic signed [16:0] prod;
  acc_t               acc;
  acc_t               acc_nxt;
  logic               k_last;
  logic               j_last;
  logic               i_last;

  assign k_last = (k_idx == n_q - 4'd1);
  assign j_last = (j_idx == p_q - 4'd1);
  assign i_last = (i_idx == m_q - 4'd1);

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state    <= poll;
      cmd_cnt  <= '0;
      i_idx    <= '0;
      j_idx    <= '0;
      k_idx    <= '0;
      prod_vld <= 1'b0;
    end else begin
      prod_vld <= (state == compute);
      case (state)
        poll: begin
          cmd_cnt <= '0;
          if (ctrl_rdata == FLAG_START) state <= load_cmd;
        end
        load_cmd: begin
          cmd_cnt <= cmd_cnt + 2'd1;
          if (cmd_cnt == 2'd2) begin
            state <= compute;
            i_idx <= '0;
            j_idx <= '0;
            k_idx <= '0;
          end
        end
        compute: begin
          k_idx <= k_idx + 4'd1;
          if (k_last) state <= store;
        end
        store: begin
          k_idx <= '0;
          if (j_last) begin
            j_idx <= '0;
            i_idx <= i_idx + 4'd1;
          end else begin
            j_idx <= j_idx + 4'd1;
          end
          state <= (i_last && j_last) ? signal : compute;
        end
        signal:  state <= poll;
        default: state <= poll;
      endcase
    end
  end

  // command words arrive one cycle after their address
  always_ff @(posedge arm_clk) begin
    if (state == load_cmd && cmd_cnt == 2'd1) begin
      m_q <= dim_t'(ctrl_rdata[3:0]);
      p_q <= dim_t'(ctrl_rdata[19:16]);
    end
    if (state == load_cmd && cmd_cnt == 2'd2) begin
      n_q <= dim_t'(ctrl_rdata[3:0]);
    end
    if (state == compute) begin
      acc <= acc_nxt;
    end else begin
      acc <= '0; // last product is folded in during store
    end
  end

  // unsigned feature times signed weight
  assign f_byte  = fm_rdata[8*i_idx[1:0] +: 8];
  assign w_byte  = wm_rdata[8*j_idx[1:0] +: 8];
  assign prod    = $signed({1'b0, f_byte}) * $signed(w_byte);
  assign acc_nxt = prod_vld ? acc + acc_t'(prod) : acc;

  assign fm_addr  = waddr_t'(k_idx) * waddr_t'(words_of(m_q)) + waddr_t'(i_idx >> 2);
  assign wm_addr  = waddr_t'(k_idx) * waddr_t'(words_of(p_q)) + waddr_t'(j_idx >> 2);
  assign out_addr = waddr_t'(i_idx) * waddr_t'(p_q) + waddr_t'(j_idx); // row-major

  assign out_we    = {WORD_BYTES{state == store}};
  assign out_wdata = word_t'(acc_nxt);

  always_comb begin
    ctrl_addr = CTRL_FLAG;
    if (state == load_cmd) begin
      ctrl_addr = (cmd_cnt == 2'd0) ? CTRL_COM1 : CTRL_COM2;
    end
  end

  assign ctrl_we    = {WORD_BYTES{state == signal}};
  assign ctrl_wdata = FLAG_FINISH;

endmodule

// File: mm_monitor.sv
module mm_monitor
  import mm_pkg::*;
(
  input logic arm_clk,
  input logic load_valid,
  input logic load_credit,
  input logic res_valid,
  input acc_t res_data,
  input logic done
);

  timeunit 1ns;
  timeprecision 100ps;

  int    feat [MAX_DIM][MAX_DIM]; // [row][k], features are unsigned
  int    wgt  [MAX_DIM][MAX_DIM]; // [k][col], weights are signed
  acc_t  exp_q [$];
  string name;
  int    n_exp;
  int    n_res;
  int    words;
  int    credits;
  int    job_errs;
  bit    active = 1'b0;
  bit    started = 1'b0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    err_total = 0; // errors outside any job

  task automatic set_feature(int row, int k, byte_t v);
    feat[row][k] = int'(v);
  endtask

  task automatic set_weight(int k, int col, byte_t v);
    wgt[k][col] = int'($signed(v));
  endtask

  // expected sums in row-major order
  task automatic new_job(string test, int m, int n, int p);
    int sum;
    exp_q.delete();
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < p; j++) begin
        sum = 0;
        for (int k = 0; k < n; k++) sum += feat[i][k] * wgt[k][j];
        exp_q.push_back(acc_t'(sum));
      end
    end
    name     = test;
    n_exp    = m * p;
    n_res    = 0;
    words    = 0;
    credits  = 0;
    job_errs = 0;
    active   = 1'b1;
    started  = 1'b1;
  endtask

  task automatic check_result(acc_t got);
    acc_t want;
    if (!active || exp_q.size() == 0) begin
      $display("ERROR: result word %0d arrived while none was expected", got);
      if (active) job_errs++;
      else err_total++;
    end else begin
      want = exp_q.pop_front();
      if (got !== want) begin
        $display("FAIL %s word %0d expected %0d actual %0d", name, n_res, want, got);
        job_errs++;
      end
    end
    n_res++;
  endtask

  task automatic finish_job();
    if (!active) begin
      $display("ERROR: done pulse with no job running");
      err_total++;
    end else begin
      if (n_res != n_exp) begin
        $display("ERROR %s: %0d result words, expected %0d", name, n_res, n_exp);
        job_errs++;
      end
      if (credits != words) begin
        $display("ERROR %s: %0d input words sent, %0d credits back", name, words, credits);
        job_errs++;
      end
      if (job_errs == 0) begin
        $display("test %s passed, %0d results", name, n_res);
        pass_cnt++;
      end else begin
        $display("test %s failed with %0d errors", name, job_errs);
        fail_cnt++;
      end
      active = 1'b0;
    end
  endtask

  always @(posedge arm_clk) begin
    if (active && load_valid) words++; // inputs settle at the falling edge
  end

  always @(negedge arm_clk) begin
    if (!started && (done || res_valid || load_credit)) begin
      $display("ERROR: DUT output active before the first job");
      err_total++;
    end
    if (load_credit) credits++;
    if (active && (words - credits > LOAD_CREDITS || credits > words)) begin
      $display("ERROR %s: %0d input words outstanding", name, words - credits);
      job_errs++;
    end
    if (res_valid) check_result(res_data);
    if (done) finish_job();
  end

endmodule

// File: mm_pkg.sv
package mm_pkg;

  // data widths
  typedef logic        [31:0] word_t;
  typedef logic        [3:0]  dim_t;   // 1..MAX_DIM
  typedef logic        [7:0]  byte_t;
  typedef logic signed [31:0] acc_t;   // also the result word
  typedef logic        [7:0]  waddr_t; // word address, all memories

  localparam int WORD_BYTES = 4;
  typedef logic [WORD_BYTES-1:0] be_t;  // byte write enables

  typedef enum logic [2:0] {
    idle,
    write_fm,
    write_wm,
    write_com,
    write_flag,
    wait_flag,
    read_out,
    finish
  } host_state_t;

  typedef enum logic [2:0] {
    poll,
    load_cmd,
    compute,
    store,
    signal
  } eng_state_t;

  localparam int MAX_DIM      = 8;
  localparam int LOAD_CREDITS = 2; // held by the input side at job start
  localparam int RES_CREDITS  = 4; // held by the sequencer for result reads

  // control memory map
  localparam waddr_t CTRL_FLAG = 8'd0;
  localparam waddr_t CTRL_COM1 = 8'd1; // {P, M}
  localparam waddr_t CTRL_COM2 = 8'd2; // {N}

  // flag word toggles between these two only
  localparam word_t FLAG_START  = 32'h5354_4152;
  localparam word_t FLAG_FINISH = 32'h4649_4e49;

  // words needed for d bytes packed four to a word
  function automatic dim_t words_of(dim_t d);
    return dim_t'((d + 4'd3) >> 2);
  endfunction

endpackage

// File: mm_system_top.sv
module mm_system_top
  import mm_pkg::*;
#(
  parameter int FM_DEPTH   = 16,
  parameter int WM_DEPTH   = 16,
  parameter int CTRL_DEPTH = 4,
  parameter int OUT_DEPTH  = 64
) (
  input  logic  arm_clk,
  input  logic  rst,
  input  logic  start,
  input  dim_t  dim_m,
  input  dim_t  dim_n,
  input  dim_t  dim_p,
  input  logic  load_valid,
  input  word_t load_data,
  input  logic  res_credit,
  output logic  done,
  output logic  load_credit,
  output logic  res_valid,
  output acc_t  res_data
);

  // host drives port A
  be_t    h_fm_we;
  be_t    h_wm_we;
  be_t    h_ctrl_we;
  waddr_t h_fm_addr;
  waddr_t h_wm_addr;
  waddr_t h_ctrl_addr;
  waddr_t h_out_addr;
  word_t  h_fm_wdata;
  word_t  h_wm_wdata;
  word_t  h_ctrl_wdata;
  word_t  h_ctrl_rdata;
  word_t  h_out_rdata;
  // engine drives port B
  be_t    e_ctrl_we;
  be_t    e_out_we;
  waddr_t e_fm_addr;
  waddr_t e_wm_addr;
  waddr_t e_ctrl_addr;
  waddr_t e_out_addr;
  word_t  e_ctrl_wdata;
  word_t  e_out_wdata;
  word_t  e_fm_rdata;
  word_t  e_wm_rdata;
  word_t  e_ctrl_rdata;

  host_sequencer i_seq (
    .arm_clk, .rst, .start, .dim_m, .dim_n, .dim_p,
    .load_valid, .load_data, .res_credit,
    .ctrl_rdata (h_ctrl_rdata), .out_rdata (h_out_rdata),
    .done, .load_credit, .res_valid, .res_data,
    .fm_we      (h_fm_we),      .wm_we     (h_wm_we),     .ctrl_we  (h_ctrl_we),
    .fm_addr    (h_fm_addr),    .wm_addr   (h_wm_addr),
    .ctrl_addr  (h_ctrl_addr),  .out_addr  (h_out_addr),
    .fm_wdata   (h_fm_wdata),   .wm_wdata  (h_wm_wdata),  .ctrl_wdata (h_ctrl_wdata)
  );

  mm_engine i_eng (
    .arm_clk, .rst,
    .fm_rdata  (e_fm_rdata),  .wm_rdata  (e_wm_rdata),  .ctrl_rdata (e_ctrl_rdata),
    .fm_addr   (e_fm_addr),   .wm_addr   (e_wm_addr),
    .ctrl_addr (e_ctrl_addr), .out_addr  (e_out_addr),
    .ctrl_we   (e_ctrl_we),   .out_we    (e_out_we),
    .ctrl_wdata (e_ctrl_wdata), .out_wdata (e_out_wdata)
  );

  // engine only reads the matrices
  tdp_ram #(.DEPTH(FM_DEPTH)) fm_ram (
    .arm_clk,
    .a_we (h_fm_we), .a_addr (h_fm_addr),
    .a_wdata (h_fm_wdata), .a_rdata (),
    .b_we ('0), .b_addr (e_fm_addr), .b_wdata ('0), .b_rdata (e_fm_rdata)
  );

  tdp_ram #(.DEPTH(WM_DEPTH)) wm_ram (
    .arm_clk,
    .a_we (h_wm_we), .a_addr (h_wm_addr), .a_wdata (h_wm_wdata), .a_rdata (),
    .b_we ('0), .b_addr (e_wm_addr), .b_wdata ('0), .b_rdata (e_wm_rdata)
  );

  tdp_ram #(.DEPTH(CTRL_DEPTH)) ctrl_ram (
    .arm_clk,
    .a_we (h_ctrl_we), .a_addr (h_ctrl_addr), .a_wdata (h_ctrl_wdata),
    .a_rdata (h_ctrl_rdata),
    .b_we (e_ctrl_we), .b_addr (e_ctrl_addr), .b_wdata (e_ctrl_wdata),
    .b_rdata (e_ctrl_rdata)
  );

  // host side of the output memory is read-only
  tdp_ram #(.DEPTH(OUT_DEPTH)) out_ram (
    .arm_clk,
    .a_we ('0), .a_addr (h_out_addr), .a_wdata ('0), .a_rdata (h_out_rdata),
    .b_we (e_out_we), .b_addr (e_out_addr), .b_wdata (e_out_wdata), .b_rdata ()
  );

endmodule

// File: mm_tb.sv
module mm_tb
  import mm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_STALL = 4;  // longest gap between result credits, cycles
  localparam int MARGIN    = 40; // per job

  typedef struct {
    string name;
    int    m;
    int    n;
    int    p;
    bit    stall;
  } job_t;

  logic  arm_clk;
  logic  rst;
  logic  start;
  dim_t  dim_m;
  dim_t  dim_n;
  dim_t  dim_p;
  logic  load_valid;
  word_t load_data;
  logic  res_credit;
  logic  done;
  logic  load_credit;
  logic  res_valid;
  acc_t  res_data;

  job_t        jobs [$];
  word_t       load_q [$];
  byte_t       fm [MAX_DIM][MAX_DIM]; // [row][k]
  byte_t       wm [MAX_DIM][MAX_DIM]; // [k][col]
  logic [31:0] rng = 32'h5d63;
  int          load_crd;  // input credits held
  int          res_owed;  // result credits not yet returned
  int          hold;      // cycles before the next result credit
  bit          stall_on;
  int          cycles = 0;
  int          limit = 0;
  bit          ended = 1'b0;

  mm_system_top i_dut (.*);

  mm_monitor i_mon (.*);

  always #2 arm_clk = ~arm_clk;

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic word_t feature_word(int k, int g, int m);
    word_t w;
    w = '0;
    for (int b = 0; b < 4; b++) begin
      if (4 * g + b < m) w[8*b +: 8] = fm[4*g+b][k]; // rows past M stay zero
    end
    return w;
  endfunction

  function automatic word_t weight_word(int k, int g, int p);
    word_t w;
    w = '0;
    for (int b = 0; b < 4; b++) begin
      if (4 * g + b < p) w[8*b +: 8] = wm[k][4*g+b];
    end
    return w;
  endfunction

  task automatic add_job(string name, int m, int n, int p, bit stall);
    job_t j;
    j.name  = name;
    j.m     = m;
    j.n     = n;
    j.p     = p;
    j.stall = stall;
    jobs.push_back(j);
  endtask

  // one clock: credits in, next word and next result credit out
  task automatic tick();
    @(negedge arm_clk);
    if (load_credit) load_crd++;
    if (load_crd > 0 && load_q.size() > 0) begin
      load_valid = 1'b1;
      load_data  = load_q.pop_front();
      load_crd--;
    end else begin
      load_valid = 1'b0;
      load_data  = '0;
    end
    if (res_valid) res_owed++;
    res_credit = 1'b0;
    if (hold > 0) begin
      hold--;
    end else if (res_owed > 0) begin
      res_credit = 1'b1;
      res_owed--;
      if (stall_on) hold = int'(lcg_next() >> 16) % MAX_STALL;
    end
  endtask

  task automatic run_job(job_t j);
    for (int i = 0; i < j.m; i++) begin
      for (int k = 0; k < j.n; k++) begin
        fm[i][k] = byte_t'(lcg_next() >> 16);
        i_mon.set_feature(i, k, fm[i][k]);
      end
    end
    for (int k = 0; k < j.n; k++) begin
      for (int c = 0; c < j.p; c++) begin
        wm[k][c] = byte_t'(lcg_next() >> 16);
        i_mon.set_weight(k, c, wm[k][c]);
      end
    end
    load_q.delete();
    for (int k = 0; k < j.n; k++) begin
      for (int g = 0; g < (j.m + 3) / 4; g++) load_q.push_back(feature_word(k, g, j.m));
    end
    for (int k = 0; k < j.n; k++) begin
      for (int g = 0; g < (j.p + 3) / 4; g++) load_q.push_back(weight_word(k, g, j.p));
    end
    i_mon.new_job(j.name, j.m, j.n, j.p);
    stall_on = j.stall;
    load_crd = LOAD_CREDITS;
    hold     = 0;
    dim_m    = dim_t'(j.m);
    dim_n    = dim_t'(j.n);
    dim_p    = dim_t'(j.p);
    start    = 1'b1;
    tick();
    start = 1'b0;
    while (!done) tick();
    // drain result credits so the next job starts with a full count
    do tick(); while (res_owed > 0);
  endtask

  initial begin
    int sum;
    int errs;
    arm_clk    = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    dim_m      = '0;
    dim_n      = '0;
    dim_p      = '0;
    load_valid = 1'b0;
    load_data  = '0;
    res_credit = 1'b0;
    res_owed   = 0;
    hold       = 0;
    stall_on   = 1'b0;
    load_crd   = LOAD_CREDITS;

    add_job("basic_4x4x4", 4, 4, 4, 1'b0);
    add_job("odd_3x5x7",   3, 5, 7, 1'b0);
    add_job("min_1x1x1",   1, 1, 1, 1'b0);
    add_job("max_8x8x8",   8, 8, 8, 1'b0);
    add_job("stall_5x3x6", 5, 3, 6, 1'b1);
    add_job("stall_8x8x8", 8, 8, 8, 1'b1);
    add_job("b2b_2x7x3",   2, 7, 3, 1'b0);

    sum = 32; // reset and idle cycles
    foreach (jobs[t]) begin
      sum += jobs[t].n * ((jobs[t].m + 3) / 4 + (jobs[t].p + 3) / 4);
      sum += 2 * jobs[t].m * jobs[t].n * jobs[t].p;
      sum += jobs[t].m * jobs[t].p * MAX_STALL + MARGIN;
    end
    limit = sum;

    repeat (3) @(posedge arm_clk);
    @(negedge arm_clk);
    rst = 1'b0;
    repeat (5) tick(); // outputs must stay quiet before the first start

    foreach (jobs[t]) run_job(jobs[t]);

    errs = i_mon.fail_cnt + i_mon.err_total + i_dut.i_chk.fail_cnt;
    $display("tests %0d, passed %0d, failed %0d, other errors %0d, assertion failures %0d",
             jobs.size(), i_mon.pass_cnt, i_mon.fail_cnt, i_mon.err_total,
             i_dut.i_chk.fail_cnt);
    ended = 1'b1;
    if (errs == 0 && i_mon.pass_cnt == jobs.size()) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge arm_clk);
      cycles++;
    end
    $display("cycle limit of %0d reached, a job never signalled done", limit);
    ended = 1'b1;
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // run stopped early by an assertion
  final begin
    if (!ended) begin
      $display("run stopped before the job table finished");
      $display("TEST RESULT: FAIL");
    end
  end

endmodule

// File: tdp_ram.sv
module tdp_ram
  import mm_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic   arm_clk,
  input  be_t    a_we,
  input  waddr_t a_addr,
  input  word_t  a_wdata,
  input  be_t    b_we,
  input  waddr_t b_addr,
  input  word_t  b_wdata,
  output word_t  a_rdata,
  output word_t  b_rdata
);

  localparam int AW = $clog2(DEPTH);

  word_t         mem [DEPTH];
  logic [AW-1:0] a_idx;
  logic [AW-1:0] b_idx;

  // upper address bits fall outside the array
  assign a_idx = a_addr[AW-1:0];
  assign b_idx = b_addr[AW-1:0];

  // both ports in one block, no same-word collisions in this design
  always_ff @(posedge arm_clk) begin
    for (int bi = 0; bi < WORD_BYTES; bi++) begin
      if (a_we[bi]) begin
        mem[a_idx][8*bi +: 8] <= a_wdata[8*bi +: 8];
        a_rdata[8*bi +: 8]    <= a_wdata[8*bi +: 8]; // write-first
      end else begin
        a_rdata[8*bi +: 8] <= mem[a_idx][8*bi +: 8];
      end
      if (b_we[bi]) begin
        mem[b_idx][8*bi +: 8] <= b_wdata[8*bi +: 8];
        b_rdata[8*bi +: 8]    <= b_wdata[8*bi +: 8];
      end else begin
        b_rdata[8*bi +: 8] <= mem[b_idx][8*bi +: 8];
      end
    end
  end

endmodule
